/* Makefile */
# Verilator build and run for the SoC subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_subsystem
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/addr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module addr_decoder (
  input  soc_bus_pkg::mem_req_t mem_req_i,
  output soc_bus_pkg::mem_req_t rom_req_o,
  output soc_bus_pkg::mem_req_t clint_req_o,
  output soc_bus_pkg::mem_req_t ext_req_o,
  output soc_cfg_pkg::region_e  region_o
);

  typedef struct packed {
    soc_cfg_pkg::region_e                  idx;
    logic [soc_cfg_pkg::ADDR_WIDTH-1:0]    start_addr;
    logic [soc_cfg_pkg::ADDR_WIDTH-1:0]    end_addr;
  } rule_t;

  localparam int unsigned NUM_RULES = 3;

  // End addresses are exclusive
  localparam rule_t ADDR_MAP [NUM_RULES] = '{
    '{idx:        soc_cfg_pkg::REGION_ROM,
      start_addr: soc_cfg_pkg::ROM_BASE,
      end_addr:   soc_cfg_pkg::ROM_BASE + soc_cfg_pkg::ROM_LENGTH},
    '{idx:        soc_cfg_pkg::REGION_CLINT,
      start_addr: soc_cfg_pkg::CLINT_BASE,
      end_addr:   soc_cfg_pkg::CLINT_BASE + soc_cfg_pkg::CLINT_LENGTH},
    '{idx:        soc_cfg_pkg::REGION_EXT,
      start_addr: soc_cfg_pkg::EXT_BASE,
      end_addr:   soc_cfg_pkg::EXT_BASE + soc_cfg_pkg::EXT_LENGTH}
  };

  soc_cfg_pkg::region_e region;

  always_comb begin
    region = soc_cfg_pkg::REGION_ERR;
    for (int i = 0; i < NUM_RULES; i++) begin
      if (mem_req_i.addr >= ADDR_MAP[i].start_addr &&
          mem_req_i.addr <  ADDR_MAP[i].end_addr) begin
        region = ADDR_MAP[i].idx;
      end
    end
    // ROM is read only
    if (region == soc_cfg_pkg::REGION_ROM && mem_req_i.we) begin
      region = soc_cfg_pkg::REGION_ERR;
    end
  end

  // Idle cycles report EXT so the response side keeps the external path open
  assign region_o = mem_req_i.req ? region : soc_cfg_pkg::REGION_EXT;

  always_comb begin
    rom_req_o       = mem_req_i;
    clint_req_o     = mem_req_i;
    ext_req_o       = mem_req_i;
    rom_req_o.req   = mem_req_i.req && (region == soc_cfg_pkg::REGION_ROM);
    clint_req_o.req = mem_req_i.req && (region == soc_cfg_pkg::REGION_CLINT);
    ext_req_o.req   = mem_req_i.req && (region == soc_cfg_pkg::REGION_EXT);
  end

endmodule

`default_nettype wire

/* hw/boot_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module boot_rom (
  input  logic                                clk_i,
  input  logic                                ndmreset_n,
  input  soc_bus_pkg::mem_req_t               rom_req_i,
  output logic [soc_cfg_pkg::DATA_WIDTH-1:0]  rdata_o
);

  localparam int unsigned WORD_IDX_W = $clog2(soc_cfg_pkg::ROM_WORDS);

  logic [soc_cfg_pkg::ADDR_WIDTH-1:0] word_idx;
  logic [soc_cfg_pkg::ADDR_WIDTH-1:0] word_idx_q;

  // 64-bit word index inside the ROM region
  assign word_idx = (rom_req_i.addr - soc_cfg_pkg::ROM_BASE) >> 3;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      word_idx_q <= '0;
    end else if (rom_req_i.req) begin
      word_idx_q <= word_idx;
    end
  end

  // Region is larger than the image, the rest reads as zero
  always_comb begin
    if (word_idx_q < soc_cfg_pkg::ROM_WORDS) begin
      rdata_o = soc_cfg_pkg::BOOT_ROM_IMAGE[word_idx_q[WORD_IDX_W-1:0]];
    end else begin
      rdata_o = '0;
    end
  end

endmodule

`default_nettype wire

/* hw/bus_cut.sv */
`timescale 1ns/1ps
`default_nettype none

// One register stage for any bus payload
module bus_cut #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     ndmreset_n,
  input  payload_t in_i,
  output payload_t out_o
);

  // Cleared so that req and rvalid start low
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      out_o <= '0;
    end else begin
      out_o <= in_i;
    end
  end

endmodule

`default_nettype wire

/* hw/clint_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module clint_timer (
  input  logic                                clk_i,
  input  logic                                ndmreset_n,
  input  logic                                rtc_i,
  input  soc_bus_pkg::mem_req_t               clint_req_i,
  output logic [soc_cfg_pkg::DATA_WIDTH-1:0]  rdata_o,
  output logic                                timer_irq_o,
  output logic                                ipi_o
);

  localparam int unsigned DW = soc_cfg_pkg::DATA_WIDTH;
  localparam int unsigned AW = soc_cfg_pkg::ADDR_WIDTH;

  localparam logic [AW-1:0] MSIP_WORD     = soc_cfg_pkg::CLINT_MSIP_OFFSET >> 3;
  localparam logic [AW-1:0] MTIMECMP_WORD = soc_cfg_pkg::CLINT_MTIMECMP_OFFSET >> 3;
  localparam logic [AW-1:0] MTIME_WORD    = soc_cfg_pkg::CLINT_MTIME_OFFSET >> 3;

  function automatic logic [DW-1:0] apply_be(input logic [DW-1:0] old_val,
                                             input logic [DW-1:0] new_val,
                                             input logic [DW/8-1:0] be);
    logic [DW-1:0] res;
    res = old_val;
    for (int i = 0; i < DW / 8; i++) begin
      if (be[i]) res[8*i +: 8] = new_val[8*i +: 8];
    end
    return res;
  endfunction

  // ----------------------------------------
  // RTC synchronizer and divide by two
  // ----------------------------------------
  logic [1:0] rtc_sync_q;
  logic       rtc_prev_q;
  logic       rtc_half_q;
  logic       rtc_rise;
  logic       mtime_tick;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q <= '0;
      rtc_prev_q <= 1'b0;
      rtc_half_q <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
      rtc_half_q <= rtc_half_q ^ rtc_rise;
    end
  end

  assign rtc_rise   = rtc_sync_q[1] & ~rtc_prev_q;
  // Every second RTC edge
  assign mtime_tick = rtc_rise & rtc_half_q;

  // ----------------------------------------
  // Registers
  // ----------------------------------------
  logic [AW-1:0] word_off;
  logic          wr_msip;
  logic          wr_mtimecmp;
  logic          wr_mtime;
  logic          msip_q;
  logic [DW-1:0] mtimecmp_q;
  logic [DW-1:0] mtime_q;

  assign word_off    = (clint_req_i.addr - soc_cfg_pkg::CLINT_BASE) >> 3;
  assign wr_msip     = clint_req_i.req & clint_req_i.we & (word_off == MSIP_WORD);
  assign wr_mtimecmp = clint_req_i.req & clint_req_i.we & (word_off == MTIMECMP_WORD);
  assign wr_mtime    = clint_req_i.req & clint_req_i.we & (word_off == MTIME_WORD);

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      msip_q      <= 1'b0;
      mtimecmp_q  <= '1;
      mtime_q     <= '0;
      timer_irq_o <= 1'b0;
    end else begin
      if (wr_msip && clint_req_i.be[0]) msip_q <= clint_req_i.wdata[0];
      if (wr_mtimecmp) mtimecmp_q <= apply_be(mtimecmp_q, clint_req_i.wdata, clint_req_i.be);
      // Bus write wins over the tick
      if (wr_mtime) begin
        mtime_q <= apply_be(mtime_q, clint_req_i.wdata, clint_req_i.be);
      end else if (mtime_tick) begin
        mtime_q <= mtime_q + 1'b1;
      end
      timer_irq_o <= (mtime_q >= mtimecmp_q);
    end
  end

  // Read data the cycle after the request, zero for writes
  always_ff @(posedge clk_i) begin
    rdata_o <= '0;
    if (clint_req_i.req && !clint_req_i.we) begin
      if (word_off == MSIP_WORD)     rdata_o <= {{(DW-1){1'b0}}, msip_q};
      if (word_off == MTIMECMP_WORD) rdata_o <= mtimecmp_q;
      if (word_off == MTIME_WORD)    rdata_o <= mtime_q;
    end
  end

  assign ipi_o = msip_q;

endmodule

`default_nettype wire

/* hw/debug_req_gate.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_req_gate #(
  parameter int unsigned DBG_DELAY_CYCLES = 500
) (
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic debug_req_i,
  output logic debug_req_o
);

  localparam int unsigned CNT_W = (DBG_DELAY_CYCLES > 0) ? $clog2(DBG_DELAY_CYCLES + 1) : 1;

  logic [CNT_W-1:0] cnt_q;

  // Gives the boot code time to run before a halt request can land
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q <= CNT_W'(DBG_DELAY_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = debug_req_i & (cnt_q == '0);

endmodule

`default_nettype wire

/* hw/rsp_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module rsp_mux (
  input  logic                                clk_i,
  input  logic                                ndmreset_n,
  input  soc_cfg_pkg::region_e                region_i,
  input  logic [soc_cfg_pkg::DATA_WIDTH-1:0]  rom_rdata_i,
  input  logic [soc_cfg_pkg::DATA_WIDTH-1:0]  clint_rdata_i,
  input  soc_bus_pkg::mem_rsp_t               ext_rsp_i,
  output soc_bus_pkg::mem_rsp_t               mem_rsp_o
);

  // Region of the previous cycle, EXT when nothing internal is pending
  soc_cfg_pkg::region_e region_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      region_q <= soc_cfg_pkg::REGION_EXT;
    end else begin
      region_q <= region_i;
    end
  end

  // ----------------------------------------
  // Response select
  // ----------------------------------------
  always_comb begin
    unique case (region_q)
      soc_cfg_pkg::REGION_ROM: begin
        mem_rsp_o = '{rvalid: 1'b1, err: 1'b0, rdata: rom_rdata_i};
      end
      soc_cfg_pkg::REGION_CLINT: begin
        // CLINT already returns zero data for writes
        mem_rsp_o = '{rvalid: 1'b1, err: 1'b0, rdata: clint_rdata_i};
      end
      soc_cfg_pkg::REGION_ERR: begin
        mem_rsp_o = '{rvalid: 1'b1, err: 1'b1, rdata: '0};
      end
      default: begin
        mem_rsp_o = ext_rsp_i;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hw/soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

  // Request from the single master, valid while req is high
  typedef struct packed {
    logic                                  req;
    logic                                  we;
    logic [soc_cfg_pkg::ADDR_WIDTH-1:0]    addr;
    logic [soc_cfg_pkg::BE_WIDTH-1:0]      be;
    logic [soc_cfg_pkg::DATA_WIDTH-1:0]    wdata;
  } mem_req_t;

  // One response per request, marked by an rvalid pulse
  typedef struct packed {
    logic                                  rvalid;
    logic                                  err;
    logic [soc_cfg_pkg::DATA_WIDTH-1:0]    rdata;
  } mem_rsp_t;

  // Reads of rdata only make sense for a read response
  // Write and error responses return zero data

endpackage

`default_nettype wire

/* hw/soc_cfg_pkg.sv */
`default_nettype none

package soc_cfg_pkg;

  // Bus geometry
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 64;
  localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;

  // Target class of a request, REGION_EXT also marks an idle cycle
  typedef enum logic [1:0] {
    REGION_ROM   = 2'd0,
    REGION_CLINT = 2'd1,
    REGION_EXT   = 2'd2,
    REGION_ERR   = 2'd3
  } region_e;

  // ----------------------------------------
  // Address map
  // ----------------------------------------
  localparam logic [ADDR_WIDTH-1:0] ROM_BASE     = 32'h0001_0000;
  localparam logic [ADDR_WIDTH-1:0] ROM_LENGTH   = 32'h0001_0000;
  localparam logic [ADDR_WIDTH-1:0] CLINT_BASE   = 32'h0200_0000;
  localparam logic [ADDR_WIDTH-1:0] CLINT_LENGTH = 32'h0000_C000;
  localparam logic [ADDR_WIDTH-1:0] EXT_BASE     = 32'h1C00_0000;
  localparam logic [ADDR_WIDTH-1:0] EXT_LENGTH   = 32'h0080_0000;

  // Register offsets inside the CLINT
  localparam logic [ADDR_WIDTH-1:0] CLINT_MSIP_OFFSET     = 32'h0000_0000;
  localparam logic [ADDR_WIDTH-1:0] CLINT_MTIMECMP_OFFSET = 32'h0000_4000;
  localparam logic [ADDR_WIDTH-1:0] CLINT_MTIME_OFFSET    = 32'h0000_BFF8;

  // ----------------------------------------
  // Boot ROM contents
  // ----------------------------------------
  localparam int unsigned ROM_WORDS = 8;

  // Two RV64 instructions per word, low half executes first
  localparam logic [DATA_WIDTH-1:0] BOOT_ROM_IMAGE [ROM_WORDS] = '{
    64'h0182_b283_0000_0297,
    64'h0202_859b_f140_2573,
    64'h0000_0013_0002_8067,
    64'h1050_0073_0000_0013,
    64'hffdf_f06f_1050_0073,
    64'h1c00_0000_0000_0000,
    64'h0000_0000_0200_0000,
    64'hdead_beef_cafe_f00d
  };

endpackage

`default_nettype wire

/* hw/soc_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_subsystem #(
  parameter int unsigned DBG_DELAY_CYCLES = 500
) (
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  logic                  rtc_i,
  input  logic                  debug_req_i,
  input  soc_bus_pkg::mem_req_t mem_req_i,
  output soc_bus_pkg::mem_rsp_t mem_rsp_o,
  output soc_bus_pkg::mem_req_t ext_req_o,
  input  soc_bus_pkg::mem_rsp_t ext_rsp_i,
  output logic                  timer_irq_o,
  output logic                  ipi_o,
  output logic                  debug_req_o
);

  soc_bus_pkg::mem_req_t              rom_req;
  soc_bus_pkg::mem_req_t              clint_req;
  soc_bus_pkg::mem_req_t              ext_req;
  soc_bus_pkg::mem_rsp_t              ext_rsp_q;
  soc_cfg_pkg::region_e               region;
  logic [soc_cfg_pkg::DATA_WIDTH-1:0] rom_rdata;
  logic [soc_cfg_pkg::DATA_WIDTH-1:0] clint_rdata;

  // ----------------------------------------
  // Request side
  // ----------------------------------------
  addr_decoder u_addr_decoder (
    .mem_req_i   ( mem_req_i ),
    .rom_req_o   ( rom_req   ),
    .clint_req_o ( clint_req ),
    .ext_req_o   ( ext_req   ),
    .region_o    ( region    )
  );

  boot_rom u_boot_rom (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .rom_req_i  ( rom_req    ),
    .rdata_o    ( rom_rdata  )
  );

  clint_timer u_clint_timer (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .clint_req_i ( clint_req   ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  // External port, one register cut each way
  bus_cut #(.payload_t(soc_bus_pkg::mem_req_t)) u_ext_req_cut (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .in_i       ( ext_req    ),
    .out_o      ( ext_req_o  )
  );

  bus_cut #(.payload_t(soc_bus_pkg::mem_rsp_t)) u_ext_rsp_cut (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .in_i       ( ext_rsp_i  ),
    .out_o      ( ext_rsp_q  )
  );

  // ----------------------------------------
  // Response side
  // ----------------------------------------
  rsp_mux u_rsp_mux (
    .clk_i         ( clk_i       ),
    .ndmreset_n    ( ndmreset_n  ),
    .region_i      ( region      ),
    .rom_rdata_i   ( rom_rdata   ),
    .clint_rdata_i ( clint_rdata ),
    .ext_rsp_i     ( ext_rsp_q   ),
    .mem_rsp_o     ( mem_rsp_o   )
  );

  debug_req_gate #(.DBG_DELAY_CYCLES(DBG_DELAY_CYCLES)) u_debug_req_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

`default_nettype wire

/* tb.f */
hw/soc_cfg_pkg.sv
hw/soc_bus_pkg.sv
hw/addr_decoder.sv
hw/boot_rom.sv
hw/clint_timer.sv
hw/bus_cut.sv
hw/rsp_mux.sv
hw/debug_req_gate.sv
hw/soc_subsystem.sv
verification/soc_subsystem_assertions.sv
verification/tb_soc_subsystem.sv

/* verification/soc_subsystem_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_subsystem_assertions (
  input logic                  clk_i,
  input logic                  ndmreset_n,
  input soc_bus_pkg::mem_req_t mem_req_i,
  input soc_bus_pkg::mem_rsp_t mem_rsp_i,
  input soc_bus_pkg::mem_req_t ext_req_i,
  input soc_cfg_pkg::region_e  region_i
);

  int unsigned fail_cnt = 0;
  logic        ext_req;
  logic        ext_pending_q;

  assign ext_req = mem_req_i.req && (region_i == soc_cfg_pkg::REGION_EXT);

  // Set by an external request, cleared by its response
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      ext_pending_q <= 1'b0;
    end else if (ext_req) begin
      ext_pending_q <= 1'b1;
    end else if (mem_rsp_i.rvalid) begin
      ext_pending_q <= 1'b0;
    end
  end

  internal_rsp_next_cycle: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    mem_req_i.req && (region_i != soc_cfg_pkg::REGION_EXT) |=> mem_rsp_i.rvalid
  ) else begin
    fail_cnt++;
    $error("internal request got no response in the next cycle");
  end

  no_req_while_ext_pending: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    ext_pending_q && !mem_rsp_i.rvalid |-> !mem_req_i.req
  ) else begin
    fail_cnt++;
    $error("request issued while an external request is outstanding");
  end

  ext_req_one_cycle_later: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    ext_req |=> ext_req_i.req
  ) else begin
    fail_cnt++;
    $error("external request did not reach ext_req_o one cycle later");
  end

endmodule

bind soc_subsystem soc_subsystem_assertions u_soc_subsystem_assertions (
  .clk_i      ( clk_i      ),
  .ndmreset_n ( ndmreset_n ),
  .mem_req_i  ( mem_req_i  ),
  .mem_rsp_i  ( mem_rsp_o  ),
  .ext_req_i  ( ext_req_o  ),
  .region_i   ( region     )
);

`default_nettype wire

/* verification/tb_soc_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_soc_subsystem;

  localparam int unsigned DBG_DELAY      = 40;
  // Expected mtime count N after 2N RTC edges
  localparam int unsigned RTC_EDGES      = 10;
  localparam int unsigned EXT_ACCESSES   = 40;
  localparam int unsigned EXT_WAIT_LIMIT = 16;
  // Whole run needs well under 1000 cycles
  // Each external access takes at most 9 cycles
  localparam int unsigned TIMEOUT_CYCLES = 20000;
  localparam logic [31:0] RNG_SEED       = 32'h4ee4222d;

  localparam logic [31:0] MSIP_ADDR     = soc_cfg_pkg::CLINT_BASE + soc_cfg_pkg::CLINT_MSIP_OFFSET;
  localparam logic [31:0] MTIMECMP_ADDR =
    soc_cfg_pkg::CLINT_BASE + soc_cfg_pkg::CLINT_MTIMECMP_OFFSET;
  localparam logic [31:0] MTIME_ADDR    = soc_cfg_pkg::CLINT_BASE + soc_cfg_pkg::CLINT_MTIME_OFFSET;
  // Just past the end of each region, and the top of the address space
  localparam logic [31:0] UNMAPPED_ADDRS [4] = '{
    32'h0002_0000, 32'h0200_C000, 32'h1C80_0000, 32'hFFFF_FFF8
  };

  logic                  clk_i;
  logic                  ndmreset_n;
  logic                  rtc_i;
  logic                  debug_req_i;
  soc_bus_pkg::mem_req_t mem_req_i;
  soc_bus_pkg::mem_rsp_t mem_rsp_o;
  soc_bus_pkg::mem_req_t ext_req_o;
  soc_bus_pkg::mem_rsp_t ext_rsp_i;
  logic                  timer_irq_o;
  logic                  ipi_o;
  logic                  debug_req_o;

  int unsigned err_cnt   = 0;
  int unsigned check_cnt = 0;
  int unsigned test_cnt  = 0;
  int unsigned cycle_cnt = 0;

  // External memory contents and expected view keyed by word address
  logic [63:0] ext_mem [logic [31:0]];
  logic [63:0] exp_mem [logic [31:0]];

  soc_subsystem #(.DBG_DELAY_CYCLES(DBG_DELAY)) u_soc_subsystem (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .debug_req_i ( debug_req_i ),
    .mem_req_i   ( mem_req_i   ),
    .mem_rsp_o   ( mem_rsp_o   ),
    .ext_req_o   ( ext_req_o   ),
    .ext_rsp_i   ( ext_rsp_i   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       ),
    .debug_req_o ( debug_req_o )
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic check_value(input string name, input logic [127:0] actual,
                             input logic [127:0] expected);
    check_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("Error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
    end
  endtask

  task automatic expect_rsp(input soc_bus_pkg::mem_rsp_t rsp, input logic err,
                            input logic [63:0] rdata);
    check_value("mem_rsp_o.rvalid", rsp.rvalid, 1'b1);
    check_value("mem_rsp_o.err", rsp.err, err);
    check_value("mem_rsp_o.rdata", rsp.rdata, rdata);
  endtask

  task automatic report_test(input string name, input int unsigned errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("[%0d ns] %s: ok", $time, name);
    end else begin
      $display("[%0d ns] %s: %0d errors", $time, name, err_cnt - errs_before);
    end
  endtask

  function automatic logic [63:0] fill_word(input logic [31:0] addr);
    return {~addr, addr};
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
                                              input logic [63:0] new_word,
                                              input logic [7:0]  be);
    logic [63:0] res;
    res = old_word;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Memory model answering the request on ext_req_o after 0 to 5 cycles
  task automatic serve_ext_request(input soc_bus_pkg::mem_req_t req);
    int unsigned delay;
    logic [63:0] word;
    delay = $urandom % 6;
    repeat (delay) begin
      @(posedge clk_i);
      #1;
    end
    word = ext_mem.exists(req.addr) ? ext_mem[req.addr] : fill_word(req.addr);
    if (req.we) begin
      ext_mem[req.addr] = merge_bytes(word, req.wdata, req.be);
    end
    ext_rsp_i = '{rvalid: 1'b1, err: 1'b0, rdata: req.we ? 64'd0 : word};
  endtask

  // Issues one request and waits for its response
  // ext_seen holds ext_req_o one cycle after the request
  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [7:0] be,
                            input logic [63:0] wdata, output soc_bus_pkg::mem_rsp_t rsp,
                            output soc_bus_pkg::mem_req_t ext_seen);
    int unsigned waited;
    @(posedge clk_i);
    #1;
    mem_req_i = '{req: 1'b1, we: we, addr: addr, be: be, wdata: wdata};
    @(posedge clk_i);
    #1;
    mem_req_i = '0;
    ext_seen  = ext_req_o;
    if (ext_req_o.req) begin
      serve_ext_request(ext_req_o);
      waited = 0;
      while (!mem_rsp_o.rvalid && waited < EXT_WAIT_LIMIT) begin
        @(posedge clk_i);
        #1;
        ext_rsp_i = '0;
        waited++;
      end
      if (!mem_rsp_o.rvalid) begin
        err_cnt++;
        $display("No response on mem_rsp_o for the external request to 0x%08h", addr);
      end
    end
    rsp = mem_rsp_o;
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic debug_gate_holdoff();
    repeat (DBG_DELAY - 2) @(posedge clk_i);
    #1;
    check_value("debug_req_o", debug_req_o, 1'b0);
    repeat (3) @(posedge clk_i);
    #1;
    check_value("debug_req_o", debug_req_o, 1'b1);
  endtask

  task automatic boot_rom_reads();
    soc_bus_pkg::mem_rsp_t rsp;
    soc_bus_pkg::mem_req_t ext_seen;
    for (int i = 0; i <= soc_cfg_pkg::ROM_WORDS; i++) begin
      bus_access(1'b0, soc_cfg_pkg::ROM_BASE + 32'(i * 8), 8'hFF, 64'd0, rsp, ext_seen);
      if (i < soc_cfg_pkg::ROM_WORDS) begin
        expect_rsp(rsp, 1'b0, soc_cfg_pkg::BOOT_ROM_IMAGE[i]);
      end else begin
        expect_rsp(rsp, 1'b0, 64'd0);
      end
    end
    bus_access(1'b1, soc_cfg_pkg::ROM_BASE, 8'hFF, 64'h5555_aaaa_5555_aaaa, rsp, ext_seen);
    expect_rsp(rsp, 1'b1, 64'd0);
  endtask

  task automatic unmapped_accesses();
    soc_bus_pkg::mem_rsp_t rsp;
    soc_bus_pkg::mem_req_t ext_seen;
    for (int i = 0; i < 4; i++) begin
      for (int w = 0; w < 2; w++) begin
        bus_access(1'(w), UNMAPPED_ADDRS[i], 8'hFF, 64'hFFFF_0000_FFFF_0000, rsp, ext_seen);
        expect_rsp(rsp, 1'b1, 64'd0);
        check_value("ext_req_o.req", ext_seen.req, 1'b0);
      end
    end
  endtask

  task automatic clint_registers();
    soc_bus_pkg::mem_rsp_t rsp;
    soc_bus_pkg::mem_req_t ext_seen;
    logic [63:0]           v;
    v = 64'h0000_0001_2345_6789;
    bus_access(1'b1, MSIP_ADDR, 8'hFF, 64'd1, rsp, ext_seen);
    expect_rsp(rsp, 1'b0, 64'd0);
    check_value("ipi_o", ipi_o, 1'b1);
    bus_access(1'b1, MSIP_ADDR, 8'hFF, 64'd0, rsp, ext_seen);
    check_value("ipi_o", ipi_o, 1'b0);
    bus_access(1'b1, MTIMECMP_ADDR, 8'hFF, 64'h0123_4567_89AB_CDEF, rsp, ext_seen);
    bus_access(1'b0, MTIMECMP_ADDR, 8'hFF, 64'd0, rsp, ext_seen);
    expect_rsp(rsp, 1'b0, 64'h0123_4567_89AB_CDEF);
    bus_access(1'b1, MTIME_ADDR, 8'hFF, v, rsp, ext_seen);
    bus_access(1'b1, MTIMECMP_ADDR, 8'hFF, v + 64'd1000, rsp, ext_seen);
    // timer_irq_o follows the registers one cycle later
    @(posedge clk_i);
    #1;
    check_value("timer_irq_o", timer_irq_o, 1'b0);
    bus_access(1'b1, MTIMECMP_ADDR, 8'hFF, v - 64'd1, rsp, ext_seen);
    @(posedge clk_i);
    #1;
    check_value("timer_irq_o", timer_irq_o, 1'b1);
  endtask

  task automatic mtime_rate();
    soc_bus_pkg::mem_rsp_t rsp;
    soc_bus_pkg::mem_req_t ext_seen;
    logic [63:0]           mtime;
    logic [63:0]           bound;
    bus_access(1'b1, MTIME_ADDR, 8'hFF, 64'd0, rsp, ext_seen);
    // RTC period of 8 clocks with 4 high and 4 low
    for (int i = 0; i < 2 * RTC_EDGES; i++) begin
      @(posedge clk_i);
      #1;
      rtc_i = 1'b1;
      repeat (4) @(posedge clk_i);
      #1;
      rtc_i = 1'b0;
      repeat (3) @(posedge clk_i);
    end
    repeat (4) @(posedge clk_i);
    bus_access(1'b0, MTIME_ADDR, 8'hFF, 64'd0, rsp, ext_seen);
    mtime = rsp.rdata;
    // Compared against the nearest edge of the allowed window
    if (mtime < RTC_EDGES - 1) begin
      bound = RTC_EDGES - 1;
    end else if (mtime > RTC_EDGES + 1) begin
      bound = RTC_EDGES + 1;
    end else begin
      bound = mtime;
    end
    check_value("mtime", mtime, bound);
  endtask

  task automatic ext_port_traffic();
    soc_bus_pkg::mem_rsp_t rsp;
    soc_bus_pkg::mem_req_t ext_seen;
    soc_bus_pkg::mem_req_t exp_req;
    logic                  we;
    logic [31:0]           addr;
    logic [7:0]            be;
    logic [63:0]           wdata;
    logic [63:0]           exp_word;
    for (int i = 0; i < EXT_ACCESSES; i++) begin
      we       = 1'($urandom % 2);
      addr     = soc_cfg_pkg::EXT_BASE + 32'(($urandom % 8) * 8);
      be       = 8'($urandom);
      wdata    = {$urandom, $urandom};
      exp_word = exp_mem.exists(addr) ? exp_mem[addr] : fill_word(addr);
      exp_req  = '{req: 1'b1, we: we, addr: addr, be: be, wdata: wdata};
      bus_access(we, addr, be, wdata, rsp, ext_seen);
      check_value("ext_req_o", ext_seen, exp_req);
      if (we) begin
        exp_mem[addr] = merge_bytes(exp_word, wdata, be);
        expect_rsp(rsp, 1'b0, 64'd0);
      end else begin
        expect_rsp(rsp, 1'b0, exp_word);
      end
    end
  endtask

  initial begin
    int unsigned errs_before;
    int unsigned total_errs;
    void'($urandom(RNG_SEED));
    clk_i       = 1'b0;
    ndmreset_n  = 1'b0;
    rtc_i       = 1'b0;
    debug_req_i = 1'b1;
    mem_req_i   = '0;
    ext_rsp_i   = '0;
    repeat (10) @(posedge clk_i);
    #1;
    ndmreset_n = 1'b1;

    errs_before = err_cnt;
    debug_gate_holdoff();
    report_test("debug gate", errs_before);
    errs_before = err_cnt;
    boot_rom_reads();
    report_test("boot ROM reads", errs_before);
    errs_before = err_cnt;
    unmapped_accesses();
    report_test("unmapped addresses", errs_before);
    errs_before = err_cnt;
    clint_registers();
    report_test("CLINT registers", errs_before);
    errs_before = err_cnt;
    mtime_rate();
    report_test("mtime rate", errs_before);
    errs_before = err_cnt;
    ext_port_traffic();
    report_test("external port", errs_before);

    total_errs = err_cnt + u_soc_subsystem.u_soc_subsystem_assertions.fail_cnt;
    $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
             test_cnt, check_cnt, err_cnt, u_soc_subsystem.u_soc_subsystem_assertions.fail_cnt);
    if (total_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
